//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := rl_top_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+verif
hw/md_pkg.sv
hw/apb_pkg.sv
hw/rl_host_port.sv
hw/rl_pair_filter.sv
hw/rl_force_eval.sv
hw/rl_force_acc.sv
hw/rl_top.sv
verif/rl_top_tb.sv

//--- hw/apb_pkg.sv
package apb_pkg;

	localparam int APB_ADDR_WIDTH = 12;
	localparam int APB_DATA_WIDTH = 32;

	typedef struct packed {
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [APB_ADDR_WIDTH-1:0] paddr;
		logic [APB_DATA_WIDTH-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DATA_WIDTH-1:0] prdata;
		logic                      pready;
		logic                      pslverr;
	} apb_rsp_t;

	localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 12'h000;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 12'h004;
	localparam logic [APB_ADDR_WIDTH-1:0] POS_BASE   = 12'h100; // one word per particle
	localparam logic [APB_ADDR_WIDTH-1:0] FORCE_BASE = 12'h200; // 16 bytes per particle

	typedef union packed {
		struct packed {
			logic [1:0] rsvd;
			logic [9:0] z;
			logic [9:0] y;
			logic [9:0] x;
		} pos;
		struct packed {
			logic [8:0]  rsvd;
			logic [21:0] cutoff_sq;
			logic        start;
		} ctrl;
	} host_word_u;

endpackage

//--- hw/md_pkg.sv
package md_pkg;

	localparam int POS_WIDTH = 10;
	localparam int DIST_WIDTH = POS_WIDTH + 1; // signed difference of two coordinates
	localparam int R2_WIDTH = 2 * DIST_WIDTH;
	localparam int ACC_WIDTH = 32;

	// index fields in the structs, wide enough for 32 particles
	localparam int IDX_WIDTH = 5;

	// x in the low bits, same order as the host position word
	typedef struct packed {
		logic [POS_WIDTH-1:0] z;
		logic [POS_WIDTH-1:0] y;
		logic [POS_WIDTH-1:0] x;
	} pos_t;

	// one particle pair leaving the filter
	typedef struct packed {
		logic                         valid;
		logic [IDX_WIDTH-1:0]         i;
		logic [IDX_WIDTH-1:0]         j;
		logic signed [DIST_WIDTH-1:0] dx;
		logic signed [DIST_WIDTH-1:0] dy;
		logic signed [DIST_WIDTH-1:0] dz;
		logic [R2_WIDTH-1:0]          r2;
	} pair_t;

	// force on i, applied negated to j
	typedef struct packed {
		logic                        valid;
		logic [IDX_WIDTH-1:0]        i;
		logic [IDX_WIDTH-1:0]        j;
		logic signed [ACC_WIDTH-1:0] fx;
		logic signed [ACC_WIDTH-1:0] fy;
		logic signed [ACC_WIDTH-1:0] fz;
	} force_upd_t;

endpackage

//--- hw/rl_force_acc.sv
`timescale 1ns/10ps

module rl_force_acc
	import md_pkg::*;
#(
	parameter int NUM_PARTICLES = 16
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start_pulse,
	input  force_upd_t                       upd,
	input  logic                             walk_done,
	output logic                             acc_done,
	output logic [15:0]                      pair_count,
	input  logic [$clog2(NUM_PARTICLES)+1:0] force_addr,
	output logic [ACC_WIDTH-1:0]             force_data
);
	localparam int IDX_W = $clog2(NUM_PARTICLES);

	logic signed [ACC_WIDTH-1:0] acc [NUM_PARTICLES][3];
	logic signed [ACC_WIDTH-1:0] f [3];
	logic [IDX_W-1:0] idx_i, idx_j;
	logic [IDX_W-1:0] rd_part;
	logic [1:0] rd_axis;
	logic [2:0] done_sr; // eval depth plus the add

	assign idx_i = upd.i[IDX_W-1:0];
	assign idx_j = upd.j[IDX_W-1:0];

	always_comb begin
		f[0] = upd.fx;
		f[1] = upd.fy;
		f[2] = upd.fz;
	end

	always_ff @(posedge clk) begin
		if (reset || start_pulse) begin
			for (int p = 0; p < NUM_PARTICLES; p++)
				for (int a = 0; a < 3; a++)
					acc[p][a] <= '0;
			pair_count <= '0;
		end else if (upd.valid) begin
			for (int a = 0; a < 3; a++) begin
				acc[idx_i][a] <= acc[idx_i][a] + f[a];
				acc[idx_j][a] <= acc[idx_j][a] - f[a]; // equal and opposite
			end
			pair_count <= pair_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			done_sr <= '0;
		else
			done_sr <= {done_sr[1:0], walk_done};
	end

	assign acc_done = done_sr[2];

	assign rd_part = force_addr[IDX_W+1:2];
	assign rd_axis = force_addr[1:0];

	always_comb begin
		if (rd_axis == 2'd3)
			force_data = '0; // no fourth axis
		else
			force_data = acc[rd_part][rd_axis];
	end

endmodule

//--- hw/rl_force_eval.sv
`timescale 1ns/10ps

module rl_force_eval
	import md_pkg::*;
#(
	parameter int FORCE_SHIFT = 12
) (
	input  logic                clk,
	input  logic                reset,
	input  logic [R2_WIDTH-1:0] cutoff_sq,
	input  pair_t               pair,
	output force_upd_t          upd
);

	pair_t s1;
	logic [R2_WIDTH-1:0] s1_w;

	// displacement times weight, scaled down
	function automatic logic signed [ACC_WIDTH-1:0] scale(
		input logic signed [DIST_WIDTH-1:0] d,
		input logic [R2_WIDTH-1:0] w
	);
		logic signed [DIST_WIDTH+R2_WIDTH:0] prod;
		prod = d * $signed({1'b0, w});
		return ACC_WIDTH'(prod >>> FORCE_SHIFT);
	endfunction

	// stage 1, weight
	always_ff @(posedge clk) begin
		if (reset)
			s1.valid <= 1'b0;
		else begin
			s1 <= pair;
			s1_w <= cutoff_sq - pair.r2; // >0 when the pair passed
		end
	end

	// stage 2, force vector
	always_ff @(posedge clk) begin
		if (reset)
			upd.valid <= 1'b0;
		else begin
			upd.valid <= s1.valid; // bubbles pass through
			upd.i <= s1.i;
			upd.j <= s1.j;
			upd.fx <= scale(s1.dx, s1_w);
			upd.fy <= scale(s1.dy, s1_w);
			upd.fz <= scale(s1.dz, s1_w);
		end
	end

endmodule

//--- hw/rl_host_port.sv
`timescale 1ns/10ps

module rl_host_port
	import md_pkg::*, apb_pkg::*;
#(
	parameter int NUM_PARTICLES = 16
) (
	input  logic                               clk,
	input  logic                               reset,
	input  apb_req_t                           apb_req,
	output apb_rsp_t                           apb_rsp,
	input  logic [$clog2(NUM_PARTICLES)-1:0]   pos_addr,
	output pos_t                               pos_data,
	output logic                               start_pulse,
	output logic [R2_WIDTH-1:0]                cutoff_sq,
	input  logic                               acc_done,
	input  logic [15:0]                        pair_count,
	output logic [$clog2(NUM_PARTICLES)+1:0]   force_addr,
	input  logic [ACC_WIDTH-1:0]               force_data
);
	localparam int IDX_W = $clog2(NUM_PARTICLES);

	pos_t pos_mem [NUM_PARTICLES];
	logic busy;
	logic done;
	host_word_u wr_word;
	host_word_u rd_word;
	logic [APB_ADDR_WIDTH-1:0] pos_off;
	logic [APB_ADDR_WIDTH-1:0] force_off;
	logic [IDX_W-1:0] pos_idx;
	logic access;
	logic is_ctrl, is_status, is_pos, is_force;
	logic err;
	logic wr_ok;

	assign access = apb_req.psel && apb_req.penable;
	assign wr_word = apb_req.pwdata;
	assign pos_off = apb_req.paddr - POS_BASE;
	assign force_off = apb_req.paddr - FORCE_BASE;

	assign is_ctrl = apb_req.paddr == REG_CTRL;
	assign is_status = apb_req.paddr == REG_STATUS;
	assign is_pos = (apb_req.paddr >= POS_BASE) && (pos_off[11:2] < NUM_PARTICLES) &&
		(pos_off[1:0] == 2'b00);
	assign is_force = (apb_req.paddr >= FORCE_BASE) && (force_off[11:4] < NUM_PARTICLES) &&
		(force_off[3:2] != 2'd3) && (force_off[1:0] == 2'b00);

	assign pos_idx = pos_off[IDX_W+1:2];
	assign force_addr = {force_off[IDX_W+3:4], force_off[3:2]}; // particle, axis

	// unmapped, force write, or config write during a run
	assign err = !(is_ctrl || is_status || is_pos || is_force) ||
		(apb_req.pwrite && is_force) ||
		(apb_req.pwrite && busy && (is_pos || is_ctrl));
	assign wr_ok = access && apb_req.pwrite && !err;

	always_comb begin
		rd_word = '0;
		if (is_status)
			rd_word = {pair_count, 14'b0, done, busy};
		else if (is_ctrl)
			rd_word.ctrl.cutoff_sq = cutoff_sq;
		else if (is_pos) begin
			rd_word.pos.x = pos_mem[pos_idx].x;
			rd_word.pos.y = pos_mem[pos_idx].y;
			rd_word.pos.z = pos_mem[pos_idx].z;
		end else if (is_force)
			rd_word = force_data; // partial sums while busy
	end

	assign apb_rsp.prdata = rd_word;
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = access && err;

	always_ff @(posedge clk) begin
		if (wr_ok && is_pos)
			pos_mem[pos_idx] <= '{z: wr_word.pos.z, y: wr_word.pos.y, x: wr_word.pos.x};
		pos_data <= pos_mem[pos_addr]; // filter read, one cycle
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start_pulse <= 1'b0;
			cutoff_sq <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			start_pulse <= wr_ok && is_ctrl && wr_word.ctrl.start;
			if (wr_ok && is_ctrl)
				cutoff_sq <= wr_word.ctrl.cutoff_sq;
			if (wr_ok && is_ctrl && wr_word.ctrl.start) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (acc_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

//--- hw/rl_pair_filter.sv
`timescale 1ns/10ps

module rl_pair_filter
	import md_pkg::*;
#(
	parameter int NUM_PARTICLES = 16
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start_pulse,
	input  logic [R2_WIDTH-1:0]              cutoff_sq,
	output logic [$clog2(NUM_PARTICLES)-1:0] pos_addr,
	input  pos_t                             pos_data,
	output pair_t                            pair,
	output logic                             walk_done
);
	localparam int IDX_W = $clog2(NUM_PARTICLES);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_PARTICLES - 1);

	logic active;
	logic last;
	logic [IDX_W-1:0] i_cnt, j_cnt;
	logic act_d, last_d, prime_d;
	logic [IDX_W-1:0] i_d, j_d;
	pos_t pos_i;
	pos_t pos_next; // i+1, read as j of the first pair
	logic signed [DIST_WIDTH-1:0] dx, dy, dz;
	logic [R2_WIDTH-1:0] sq_x, sq_y, sq_z;
	logic [R2_WIDTH-1:0] r2;

	assign last = (i_cnt == LAST_IDX - 1'b1) && (j_cnt == LAST_IDX);
	assign pos_addr = active ? j_cnt : '0; // idle reads particle 0 for the prime

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			i_cnt <= '0;
			j_cnt <= '0;
		end else if (start_pulse) begin
			active <= 1'b1;
			i_cnt <= '0;
			j_cnt <= IDX_W'(1);
		end else if (active) begin
			if (last)
				active <= 1'b0;
			else if (j_cnt == LAST_IDX) begin
				i_cnt <= i_cnt + 1'b1;
				j_cnt <= IDX_W'(i_cnt + 2);
			end else
				j_cnt <= j_cnt + 1'b1;
		end
	end

	// read data stage
	always_ff @(posedge clk) begin
		if (reset) begin
			act_d <= 1'b0;
			last_d <= 1'b0;
			prime_d <= 1'b0;
		end else begin
			act_d <= active;
			last_d <= active && last;
			prime_d <= start_pulse;
		end
	end

	always_ff @(posedge clk) begin
		i_d <= i_cnt;
		j_d <= j_cnt;
		if (prime_d)
			pos_i <= pos_data;
		else if (act_d && j_d == LAST_IDX)
			pos_i <= pos_next; // i moves on next cycle
		if (act_d && j_d == IDX_W'(i_d + 1'b1))
			pos_next <= pos_data;
	end

	assign dx = $signed({1'b0, pos_i.x}) - $signed({1'b0, pos_data.x});
	assign dy = $signed({1'b0, pos_i.y}) - $signed({1'b0, pos_data.y});
	assign dz = $signed({1'b0, pos_i.z}) - $signed({1'b0, pos_data.z});

	assign sq_x = dx * dx;
	assign sq_y = dy * dy;
	assign sq_z = dz * dz;
	assign r2 = sq_x + sq_y + sq_z; // fits, max is 3 * 1023^2

	always_ff @(posedge clk) begin
		if (reset) begin
			pair.valid <= 1'b0;
			walk_done <= 1'b0;
		end else begin
			pair.valid <= act_d && (r2 < cutoff_sq);
			pair.i <= IDX_WIDTH'(i_d);
			pair.j <= IDX_WIDTH'(j_d);
			pair.dx <= dx;
			pair.dy <= dy;
			pair.dz <= dz;
			pair.r2 <= r2;
			walk_done <= last_d;
		end
	end

endmodule

//--- hw/rl_top.sv
`timescale 1ns/10ps

module rl_top
	import md_pkg::*, apb_pkg::*;
#(
	parameter int NUM_PARTICLES = 16,
	parameter int FORCE_SHIFT = 12
) (
	input  logic     clk,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);
	localparam int IDX_W = $clog2(NUM_PARTICLES);

	logic start_pulse;
	logic [R2_WIDTH-1:0] cutoff_sq;
	logic [IDX_W-1:0] pos_addr;
	pos_t pos_data;
	pair_t pair;
	logic walk_done;
	force_upd_t upd;
	logic acc_done;
	logic [15:0] pair_count;
	logic [IDX_W+1:0] force_addr;
	logic [ACC_WIDTH-1:0] force_data;

	rl_host_port #(
		.NUM_PARTICLES(NUM_PARTICLES)
	) rl_host_port (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.pos_addr(pos_addr),
		.pos_data(pos_data),
		.start_pulse(start_pulse),
		.cutoff_sq(cutoff_sq),
		.acc_done(acc_done),
		.pair_count(pair_count),
		.force_addr(force_addr),
		.force_data(force_data)
	);

	rl_pair_filter #(
		.NUM_PARTICLES(NUM_PARTICLES)
	) rl_pair_filter (
		.clk(clk),
		.reset(reset),
		.start_pulse(start_pulse),
		.cutoff_sq(cutoff_sq),
		.pos_addr(pos_addr),
		.pos_data(pos_data),
		.pair(pair),
		.walk_done(walk_done)
	);

	rl_force_eval #(
		.FORCE_SHIFT(FORCE_SHIFT)
	) rl_force_eval (
		.clk(clk),
		.reset(reset),
		.cutoff_sq(cutoff_sq),
		.pair(pair),
		.upd(upd)
	);

	rl_force_acc #(
		.NUM_PARTICLES(NUM_PARTICLES)
	) rl_force_acc (
		.clk(clk),
		.reset(reset),
		.start_pulse(start_pulse),
		.upd(upd),
		.walk_done(walk_done),
		.acc_done(acc_done),
		.pair_count(pair_count),
		.force_addr(force_addr),
		.force_data(force_data)
	);

endmodule

//--- verif/rl_model.svh
`ifndef RL_MODEL_SVH
`define RL_MODEL_SVH

// displacement of particle i from particle j along one axis
function automatic longint disp(input pos_t pi, input pos_t pj, input int axis);
	case (axis)
		0: return longint'(pi.x) - longint'(pj.x);
		1: return longint'(pi.y) - longint'(pj.y);
		default: return longint'(pi.z) - longint'(pj.z);
	endcase
endfunction

function automatic longint dist_sq(input pos_t pi, input pos_t pj);
	longint d;
	longint sum;
	sum = 0;
	for (int a = 0; a < 3; a++) begin
		d = disp(pi, pj, a);
		sum += d * d;
	end
	return sum;
endfunction

// weight is the cutoff minus r2, arithmetic shift rounds toward minus infinity
function automatic longint pair_force(input longint d, input longint r2, input longint cutoff);
	return (d * (cutoff - r2)) >>> FORCE_SHIFT;
endfunction

// half neighbour list, force added to i and taken from j
function automatic void run_model(input pos_t p[NUM_PARTICLES], input longint cutoff,
	output longint f_out[NUM_PARTICLES*3], output int pairs);
	longint r2;
	longint f;
	for (int n = 0; n < NUM_PARTICLES * 3; n++)
		f_out[n] = 0;
	pairs = 0;
	for (int i = 0; i < NUM_PARTICLES; i++)
		for (int j = i + 1; j < NUM_PARTICLES; j++) begin
			r2 = dist_sq(p[i], p[j]);
			if (r2 < cutoff) begin
				pairs++;
				for (int a = 0; a < 3; a++) begin
					f = pair_force(disp(p[i], p[j], a), r2, cutoff);
					f_out[i*3+a] += f;
					f_out[j*3+a] -= f;
				end
			end
		end
endfunction

`endif

//--- verif/rl_top_tb.sv
`timescale 1ns/10ps

module rl_top_tb
	import md_pkg::*, apb_pkg::*;
();
	localparam int NUM_PARTICLES = 16;
	localparam int FORCE_SHIFT = 12;
	localparam int SEED = 96494;
	localparam int CLK_PERIOD = 8;
	localparam int NUM_PAIRS = NUM_PARTICLES * (NUM_PARTICLES - 1) / 2;
	localparam int RUN_CYCLES = NUM_PAIRS + 5;
	localparam int NUM_RUNS = 4;
	// position loads, start, force reads and status per run, plus readback and error probes
	localparam int APB_XFERS = NUM_RUNS * (4 * NUM_PARTICLES + 2) + 2 * NUM_PARTICLES + 16;
	localparam int WATCHDOG_NS = 4 * (NUM_RUNS * RUN_CYCLES + 3 * APB_XFERS + 3) * CLK_PERIOD;

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	pos_t model_pos [NUM_PARTICLES];
	longint force_exp [NUM_PARTICLES*3];
	int pairs_exp;

	rl_top #(
		.NUM_PARTICLES(NUM_PARTICLES),
		.FORCE_SHIFT(FORCE_SHIFT)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	`include "rl_model.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check(input string name, input longint expected, input longint actual);
		if (expected !== actual)
			fail($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
	endtask

	function automatic logic [11:0] pos_reg(input int n);
		return 12'(POS_BASE + 4 * n);
	endfunction

	function automatic logic [11:0] force_reg(input int n, input int a);
		return 12'(FORCE_BASE + 16 * n + 4 * a);
	endfunction

	// setup, access, then back to idle
	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= wr;
		apb_req.paddr <= addr;
		apb_req.pwdata <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk); // access phase settled
		check("pready in access phase", 1, apb_rsp.pready);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check($sformatf("pslverr on write 0x%03h", addr), 0, err);
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		check($sformatf("pslverr on read 0x%03h", addr), 0, err);
	endtask

	task automatic load_positions();
		host_word_u w;
		for (int n = 0; n < NUM_PARTICLES; n++) begin
			model_pos[n].x = POS_WIDTH'($urandom_range(1023, 0));
			model_pos[n].y = POS_WIDTH'($urandom_range(1023, 0));
			model_pos[n].z = POS_WIDTH'($urandom_range(1023, 0));
			w = '0;
			w.pos.x = model_pos[n].x;
			w.pos.y = model_pos[n].y;
			w.pos.z = model_pos[n].z;
			write_reg(pos_reg(n), w);
		end
	endtask

	task automatic start_run(input longint cutoff);
		host_word_u w;
		w = '0;
		w.ctrl.cutoff_sq = R2_WIDTH'(cutoff);
		w.ctrl.start = 1'b1;
		write_reg(REG_CTRL, w);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int polls;
		polls = 0;
		read_reg(REG_STATUS, st);
		while (!st[1]) begin
			polls++;
			if (polls > RUN_CYCLES)
				fail("run did not finish, done bit never set in status");
			read_reg(REG_STATUS, st);
		end
		check("status busy after done", 0, st[0]);
	endtask

	task automatic check_results(input string tag, input longint cutoff);
		logic [31:0] st;
		logic [31:0] rd;
		int fv [NUM_PARTICLES*3];
		longint sum [3];
		run_model(model_pos, cutoff, force_exp, pairs_exp);
		read_reg(REG_STATUS, st);
		check({tag, " pair count"}, pairs_exp, st[31:16]);
		sum = '{0, 0, 0};
		for (int n = 0; n < NUM_PARTICLES; n++)
			for (int a = 0; a < 3; a++) begin
				read_reg(force_reg(n, a), rd);
				fv[n*3+a] = rd; // signed view
				sum[a] += fv[n*3+a];
			end
		// equal and opposite forces cancel on every axis
		for (int a = 0; a < 3; a++)
			check($sformatf("%s force sum axis %0d", tag, a), 0, sum[a]);
		for (int n = 0; n < NUM_PARTICLES * 3; n++)
			check($sformatf("%s force p%0d axis %0d", tag, n / 3, n % 3), force_exp[n], fv[n]);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail("watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] rd;
		logic err;
		longint cutoff;
		pos_t hit;
		void'($urandom(SEED));
		reset <= 1'b1;
		apb_req <= '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		read_reg(REG_STATUS, rd);
		check("status after reset", 0, rd);
		load_positions();
		for (int n = 0; n < NUM_PARTICLES; n++) begin
			read_reg(pos_reg(n), rd);
			check($sformatf("position readback p%0d", n), {2'b00, model_pos[n]}, rd);
		end

		// rejected accesses while the first run is going
		cutoff = $urandom_range(800000, 100000);
		start_run(cutoff);
		read_reg(REG_STATUS, rd);
		check("status busy during run", 1, rd[0]);
		hit = model_pos[3];
		apb_xfer(1'b1, pos_reg(3), {2'b11, ~hit}, rd, err);
		check("pslverr position write while busy", 1, err);
		apb_xfer(1'b1, REG_CTRL, 32'h1, rd, err);
		check("pslverr control write while busy", 1, err);
		apb_xfer(1'b1, force_reg(2, 1), 32'h55, rd, err);
		check("pslverr force region write", 1, err);
		apb_xfer(1'b0, 12'h008, '0, rd, err);
		check("pslverr unmapped read", 1, err);
		apb_xfer(1'b1, 12'h300, 32'h1, rd, err);
		check("pslverr unmapped write", 1, err);
		wait_done();
		read_reg(pos_reg(3), rd);
		check("position kept after rejected write", {2'b00, hit}, rd);
		check_results("run1", cutoff);

		load_positions();
		cutoff = $urandom_range(800000, 100000);
		start_run(cutoff);
		wait_done();
		check_results("run2", cutoff);

		load_positions();
		start_run(0);
		wait_done();
		check_results("zero cutoff", 0);

		cutoff = (longint'(1) << R2_WIDTH) - 1;
		start_run(cutoff);
		wait_done();
		check_results("max cutoff", cutoff);

		$display("** PASS **");
		$finish;
	end

endmodule
